// File: crc_checker_top.f
logic/pkt_format_pkg.sv
logic/crc_pkg.sv
logic/pkt_buffer.sv
logic/crc8_byte_accum.sv
logic/crc_check_ctrl.sv
logic/crc_checker_top.sv
verification/crc_checker_properties.sv
verification/crc_checker_tb.sv

// File: logic/crc8_byte_accum.sv
`timescale 1ns/1ps

module crc8_byte_accum
  import crc_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       clear_i,
  input  logic       byte_valid_i,
  input  logic [7:0] byte_i,
  output crc_t       crc_o
);

  crc_t crc_reg;
  crc_t crc_next;

  // fold one byte in, one polynomial step per bit, msb first
  always_comb begin
    crc_next = crc_reg ^ byte_i;
    for (int i = 0; i < 8; i++) begin
      if (crc_next[CRC_W-1]) begin
        crc_next = (crc_next << 1) ^ CRC_POLY;
      end else begin
        crc_next = crc_next << 1;
      end
    end
  end

  // clear wins over a byte arriving in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      crc_reg <= CRC_INIT;
    end else if (clear_i) begin
      crc_reg <= CRC_INIT;
    end else if (byte_valid_i) begin
      crc_reg <= crc_next;
    end
  end

  assign crc_o = crc_reg;

endmodule

// File: logic/crc_check_ctrl.sv
`timescale 1ns/1ps

module crc_check_ctrl
  import pkt_format_pkg::*;
  import crc_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              start_i,
  input  buf_addr_t         hdr_addr_i,
  output buf_addr_t         rd_addr_o,
  input  logic [WORD_W-1:0] rd_data_i,
  output logic              crc_clear_o,
  output logic              byte_valid_o,
  output logic [7:0]        byte_o,
  input  crc_t              crc_i,
  output logic              busy_o,
  output logic              done_o,
  output logic              crc_err_o,
  output byte_cnt_t         pkt_byte_cnt_o
);

  typedef enum logic [1:0] {
    s_idle,
    s_hdr_read,
    s_payload_read,
    s_compare
  } state_t;

  state_t    state_reg, state_next;
  buf_addr_t addr_reg, addr_next;
  byte_cnt_t byte_cnt_reg, byte_cnt_next;
  crc_t      stored_crc_reg, stored_crc_next;
  logic      err_reg, err_next;

  // counts returned words; one extra bit so byte count + 1 fits
  logic [BYTE_CNT_W:0] cnt_reg, cnt_next;
  // index of the returned word that holds the stored crc
  logic [BYTE_CNT_W:0] crc_idx;
  logic                crc_mismatch;

  assign crc_idx      = {1'b0, byte_cnt_reg} + 1'b1;
  assign crc_mismatch = (stored_crc_reg != crc_i);

  ////////////////////////////////////////////////////////////////////////
  // state and control registers

  always_ff @(posedge clk) begin
    if (reset) begin
      state_reg    <= s_idle;
      addr_reg     <= '0;
      cnt_reg      <= '0;
      byte_cnt_reg <= '0;
      err_reg      <= 1'b0;
    end else begin
      state_reg    <= state_next;
      addr_reg     <= addr_next;
      cnt_reg      <= cnt_next;
      byte_cnt_reg <= byte_cnt_next;
      err_reg      <= err_next;
    end
  end

  always_ff @(posedge clk) begin
    stored_crc_reg <= stored_crc_next;
  end

  ////////////////////////////////////////////////////////////////////////
  // next state

  always_comb begin
    state_next      = state_reg;
    addr_next       = addr_reg;
    cnt_next        = cnt_reg;
    byte_cnt_next   = byte_cnt_reg;
    stored_crc_next = stored_crc_reg;
    err_next        = err_reg;

    case (state_reg)
      s_idle: begin
        if (start_i) begin
          addr_next  = hdr_addr_i;
          cnt_next   = '0;
          err_next   = 1'b0;
          state_next = s_hdr_read;
        end
      end

      // two cycles: header address out, then header word back
      s_hdr_read: begin
        if (!cnt_reg[0]) begin
          addr_next = addr_reg + buf_addr_t'(PAYLOAD_OFFSET);
          cnt_next  = cnt_reg + 1'b1;
        end else begin
          byte_cnt_next = rd_data_i[BYTE_CNT_LSB +: BYTE_CNT_W];
          addr_next     = addr_reg + 1'b1;
          cnt_next      = '0;
          state_next    = s_payload_read;
        end
      end

      // payload words return one per cycle, the crc word right after
      s_payload_read: begin
        addr_next = addr_reg + 1'b1;
        cnt_next  = cnt_reg + 1'b1;
        if (cnt_reg == crc_idx) begin
          stored_crc_next = rd_data_i[CRC_W-1:0];
          state_next      = s_compare;
        end
      end

      s_compare: begin
        err_next   = crc_mismatch;
        state_next = s_idle;
      end

      default: begin
        state_next = s_idle;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////
  // outputs

  assign rd_addr_o = addr_reg;

  // accumulator restarts on the accepted start
  assign crc_clear_o  = start_i && (state_reg == s_idle);
  assign byte_valid_o = (state_reg == s_payload_read) && (cnt_reg != crc_idx);
  assign byte_o       = rd_data_i[7:0];

  assign busy_o = (state_reg != s_idle);
  assign done_o = (state_reg == s_compare);

  // result shows in the compare cycle and is held afterwards
  assign crc_err_o      = (state_reg == s_compare) ? crc_mismatch : err_reg;
  assign pkt_byte_cnt_o = byte_cnt_reg;

endmodule

// File: logic/crc_checker_top.sv
`timescale 1ns/1ps

module crc_checker_top
  import pkt_format_pkg::*;
  import crc_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              wr_en_i,
  input  buf_addr_t         wr_addr_i,
  input  logic [WORD_W-1:0] wr_data_i,
  input  logic              start_i,
  input  buf_addr_t         hdr_addr_i,
  output logic              busy_o,
  output logic              done_o,
  output logic              crc_err_o,
  output byte_cnt_t         pkt_byte_cnt_o
);

  buf_addr_t         rd_addr;
  logic [WORD_W-1:0] rd_data;
  logic              crc_clear;
  logic              byte_valid;
  logic [7:0]        byte_data;
  crc_t              crc_value;

  pkt_buffer buf0 (
    .clk       (clk),
    .wr_en_i   (wr_en_i),
    .wr_addr_i (wr_addr_i),
    .wr_data_i (wr_data_i),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  crc_check_ctrl ctrl0 (
    .clk            (clk),
    .reset          (reset),
    .start_i        (start_i),
    .hdr_addr_i     (hdr_addr_i),
    .rd_addr_o      (rd_addr),
    .rd_data_i      (rd_data),
    .crc_clear_o    (crc_clear),
    .byte_valid_o   (byte_valid),
    .byte_o         (byte_data),
    .crc_i          (crc_value),
    .busy_o         (busy_o),
    .done_o         (done_o),
    .crc_err_o      (crc_err_o),
    .pkt_byte_cnt_o (pkt_byte_cnt_o)
  );

  crc8_byte_accum accum0 (
    .clk          (clk),
    .reset        (reset),
    .clear_i      (crc_clear),
    .byte_valid_i (byte_valid),
    .byte_i       (byte_data),
    .crc_o        (crc_value)
  );

endmodule

// File: logic/crc_pkg.sv
package crc_pkg;

  ////////////////////////////////////////////////////////////////////////
  // crc-8, msb first, no reflection and no final xor

  localparam int CRC_W = 8;

  typedef logic [CRC_W-1:0] crc_t;

  // x^8 + x^2 + x + 1
  localparam crc_t CRC_POLY = 8'h07;
  localparam crc_t CRC_INIT = 8'h00;

endpackage

// File: logic/pkt_buffer.sv
`timescale 1ns/1ps

module pkt_buffer
  import pkt_format_pkg::*;
(
  input  logic              clk,
  input  logic              wr_en_i,
  input  buf_addr_t         wr_addr_i,
  input  logic [WORD_W-1:0] wr_data_i,
  input  buf_addr_t         rd_addr_i,
  output logic [WORD_W-1:0] rd_data_o
);

  // packet storage, one word per address
  logic [WORD_W-1:0] mem [BUF_DEPTH];

  // host write port
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // checker read port, data is back one cycle after the address
  always_ff @(posedge clk) begin
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

// File: logic/pkt_format_pkg.sv
package pkt_format_pkg;

  ////////////////////////////////////////////////////////////////////////
  // packet buffer geometry

  localparam int BUF_ADDR_W = 8;
  localparam int BUF_DEPTH  = 256;
  localparam int WORD_W     = 32;

  ////////////////////////////////////////////////////////////////////////
  // packet layout

  // header bits 7:4 hold the payload byte count minus one
  localparam int BYTE_CNT_W   = 4;
  localparam int BYTE_CNT_LSB = 4;

  // first payload byte sits two words above the header
  localparam int PAYLOAD_OFFSET = 2;

  typedef logic [BUF_ADDR_W-1:0] buf_addr_t;
  typedef logic [BYTE_CNT_W-1:0] byte_cnt_t;

endpackage

// File: verification/crc_checker_properties.sv
`timescale 1ns/1ps

module crc_checker_properties (
  input logic clk,
  input logic reset,
  input logic start_i,
  input logic busy_i,
  input logic done_i,
  input logic byte_valid_i
);

  int fail_cnt = 0;

  // done is a single-cycle pulse
  done_single_pulse: assert property (@(posedge clk) disable iff (reset) done_i |=> !done_i)
    else begin
      fail_cnt++;
      $error("done high on two consecutive cycles");
    end

  // a start taken in idle makes the sequencer busy on the next cycle
  start_sets_busy: assert property (@(posedge clk) disable iff (reset)
    (start_i && !busy_i) |=> busy_i)
    else begin
      fail_cnt++;
      $error("accepted start not followed by busy");
    end

  done_within_busy: assert property (@(posedge clk) disable iff (reset) done_i |-> busy_i)
    else begin
      fail_cnt++;
      $error("done high while not busy");
    end

  // no payload byte reaches the accumulator while idle
  no_byte_when_idle: assert property (@(posedge clk) disable iff (reset)
    !busy_i |-> !byte_valid_i)
    else begin
      fail_cnt++;
      $error("byte valid while not busy");
    end

endmodule

bind crc_check_ctrl crc_checker_properties props0 (
  .clk          (clk),
  .reset        (reset),
  .start_i      (start_i),
  .busy_i       (busy_o),
  .done_i       (done_o),
  .byte_valid_i (byte_valid_o)
);

// File: verification/crc_checker_tb.sv
`timescale 1ns/1ps

module crc_checker_tb
  import pkt_format_pkg::*;
  import crc_pkg::*;
();

  localparam int          NUM_TESTS      = 10;
  localparam logic [31:0] SEED           = 32'hddb6c3e7;
  // header, unused word, up to 16 payload bytes and the crc byte
  localparam int          WR_CYCLES      = (1 << BYTE_CNT_W) + 3;
  localparam int          TIMEOUT_CYCLES = NUM_TESTS * (WR_CYCLES + 16 + 10);
  // packet with a bad crc, target of the start issued while busy
  localparam buf_addr_t   BUSY_RESTART_ADDR = 8'h60;

  typedef enum logic [1:0] {f_none, f_bad_crc, f_bad_payload, f_busy_start} fault_t;

  typedef struct packed {
    buf_addr_t addr;
    byte_cnt_t cnt;
    fault_t    fault;
    logic      exp_err;
  } test_row_t;

  logic              clk = 1'b0;
  logic              reset;
  logic              wr_en_i;
  buf_addr_t         wr_addr_i;
  logic [WORD_W-1:0] wr_data_i;
  logic              start_i;
  buf_addr_t         hdr_addr_i;
  logic              busy_o;
  logic              done_o;
  logic              crc_err_o;
  byte_cnt_t         pkt_byte_cnt_o;

  test_row_t   tests [NUM_TESTS];
  int          err_cnt = 0;
  int          row_errs = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          done_cnt = 0;
  int unsigned cycle_cnt = 0;

  crc_checker_top dut0 (
    .clk            (clk),
    .reset          (reset),
    .wr_en_i        (wr_en_i),
    .wr_addr_i      (wr_addr_i),
    .wr_data_i      (wr_data_i),
    .start_i        (start_i),
    .hdr_addr_i     (hdr_addr_i),
    .busy_o         (busy_o),
    .done_o         (done_o),
    .crc_err_o      (crc_err_o),
    .pkt_byte_cnt_o (pkt_byte_cnt_o)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (done_o) begin
      done_cnt <= done_cnt + 1;
    end
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: done_o did not arrive within %0d cycles", TIMEOUT_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // helpers

  // bit-serial crc-8 model, msb first
  function automatic crc_t crc8_ref(input logic [7:0] data [16], input int n);
    crc_t crc;
    logic fb;
    crc = CRC_INIT;
    for (int i = 0; i < n; i++) begin
      for (int b = 7; b >= 0; b--) begin
        fb  = crc[CRC_W-1] ^ data[i][b];
        crc = crc << 1;
        if (fb) begin
          crc = crc ^ CRC_POLY;
        end
      end
    end
    return crc;
  endfunction

  // four-state compare so an unknown output never passes
  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
      err_cnt++;
      row_errs++;
    end
  endtask

  task automatic write_word(input buf_addr_t addr, input logic [WORD_W-1:0] data);
    @(negedge clk);
    wr_en_i   = 1'b1;
    wr_addr_i = addr;
    wr_data_i = data;
  endtask

  task automatic finish_row(input string name);
    if (row_errs == 0) begin
      pass_cnt++;
      $display("%s: ok", name);
    end else begin
      fail_cnt++;
      $display("%s: FAILED with %0d errors", name, row_errs);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // one packet: build, load, check

  task automatic run_test(input int idx);
    test_row_t  row;
    logic [7:0] payload [16];
    crc_t       crc;
    int         n;
    int         flip_idx;
    row      = tests[idx];
    n        = int'(row.cnt) + 1;
    row_errs = 0;
    for (int i = 0; i < n; i++) begin
      payload[i] = 8'($urandom);
    end
    crc = crc8_ref(payload, n);
    // faults go in after the crc is known
    if (row.fault == f_bad_crc) begin
      crc = crc ^ (8'h01 << $urandom_range(7, 0));
    end else if (row.fault == f_bad_payload) begin
      flip_idx = $urandom_range(n - 1, 0);
      payload[flip_idx] = payload[flip_idx] ^ (8'h01 << $urandom_range(7, 0));
    end
    write_word(row.addr, {24'($urandom), row.cnt, 4'($urandom)});
    write_word(row.addr + 8'd1, WORD_W'($urandom));
    for (int i = 0; i < n; i++) begin
      write_word(row.addr + buf_addr_t'(PAYLOAD_OFFSET + i), {24'($urandom), payload[i]});
    end
    write_word(row.addr + buf_addr_t'(PAYLOAD_OFFSET + n), {24'($urandom), crc});
    @(negedge clk);
    wr_en_i    = 1'b0;
    start_i    = 1'b1;
    hdr_addr_i = row.addr;
    @(negedge clk);
    compare_value("busy_o after start", busy_o, 1);
    if (row.fault == f_busy_start) begin
      hdr_addr_i = BUSY_RESTART_ADDR;
      @(negedge clk);
    end
    start_i = 1'b0;
    while (!done_o) begin
      @(negedge clk);
    end
    compare_value("crc_err_o at done", crc_err_o, row.exp_err);
    compare_value("pkt_byte_cnt_o at done", pkt_byte_cnt_o, row.cnt);
    compare_value("done count before this packet", done_cnt, idx);
    @(negedge clk);
    compare_value("done_o after pulse", done_o, 0);
    compare_value("busy_o after done", busy_o, 0);
    compare_value("crc_err_o held", crc_err_o, row.exp_err);
    compare_value("pkt_byte_cnt_o held", pkt_byte_cnt_o, row.cnt);
    compare_value("done count", done_cnt, idx + 1);
    if (row.fault == f_busy_start) begin
      repeat (n + 8) @(negedge clk);
      compare_value("done count after ignored start", done_cnt, idx + 1);
      compare_value("busy_o after ignored start", busy_o, 0);
    end
    finish_row($sformatf("test %0d addr %02h cnt %0d fault %s", idx, row.addr, row.cnt,
                         row.fault.name()));
  endtask

  ////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    int prop_fails;
    reset      = 1'b1;
    wr_en_i    = 1'b0;
    wr_addr_i  = '0;
    wr_data_i  = '0;
    start_i    = 1'b0;
    hdr_addr_i = '0;
    void'($urandom(SEED));
    // last three packets sit back to back in the buffer
    tests = '{
      '{8'h00, 4'd0,  f_none,        1'b0},
      '{8'h20, 4'd7,  f_none,        1'b0},
      '{8'h40, 4'd15, f_none,        1'b0},
      '{8'h60, 4'd5,  f_bad_crc,     1'b1},
      '{8'h80, 4'd9,  f_bad_payload, 1'b1},
      '{8'ha0, 4'd3,  f_none,        1'b0},
      '{8'hc0, 4'd12, f_busy_start,  1'b0},
      '{8'he0, 4'd1,  f_none,        1'b0},
      '{8'he5, 4'd4,  f_none,        1'b0},
      '{8'hed, 4'd10, f_none,        1'b0}
    };
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    compare_value("busy_o after reset", busy_o, 0);
    compare_value("done_o after reset", done_o, 0);
    compare_value("crc_err_o after reset", crc_err_o, 0);
    compare_value("pkt_byte_cnt_o after reset", pkt_byte_cnt_o, 0);
    finish_row("reset state");
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_test(i);
    end
    prop_fails = dut0.ctrl0.props0.fail_cnt;
    $display("%0d passed, %0d failed, %0d check errors, %0d property failures",
             pass_cnt, fail_cnt, err_cnt, prop_fails);
    if (fail_cnt == 0 && err_cnt == 0 && prop_fails == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
